//--- filelist.f
+incdir+.
rv32i_pkg.sv
alu.sv
cmp.sv
fwd_unit.sv
exe_stage.sv
exe_subsystem.sv
tb_exe_subsystem.sv

//--- Bender.yml
package:
  name: rv32i_exe

sources:
  - rv32i_pkg.sv
  - alu.sv
  - cmp.sv
  - fwd_unit.sv
  - exe_stage.sv
  - exe_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exe_subsystem.sv

//--- tb_exe_ref.svh
`ifndef TB_EXE_REF_SVH
`define TB_EXE_REF_SVH

// expected alu result per the RV32I definitions
function automatic rv32i_word ref_alu(alu_op_t op, rv32i_word a, rv32i_word b);
    rv32i_word f;
    case (op)
        alu_add:  f = a + b;
        alu_sub:  f = a - b;
        alu_sll:  f = a << b[4:0];
        alu_slt:  f = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu: f = (a < b) ? 32'd1 : 32'd0;
        alu_xor:  f = a ^ b;
        alu_srl:  f = a >> b[4:0];
        alu_sra:  f = rv32i_word'($signed(a) >>> b[4:0]);
        alu_or:   f = a | b;
        alu_and:  f = a & b;
        default:  f = '0;
    endcase
    return f;
endfunction

// expected branch decision
function automatic logic ref_cmp(cmp_op_t op, rv32i_word a, rv32i_word b);
    logic taken;
    case (op)
        beq:     taken = (a == b);
        bne:     taken = (a != b);
        blt:     taken = ($signed(a) < $signed(b));
        bge:     taken = ($signed(a) >= $signed(b));
        bltu:    taken = (a < b);
        bgeu:    taken = (a >= b);
        default: taken = 1'b0;
    endcase
    return taken;
endfunction

// operand value after forwarding, exe first, then mem, then wb
function automatic rv32i_word ref_operand(
    rv32i_reg  rs,
    rv32i_word rf_data,
    logic      exe_held,
    exe_mem_t  exe_last,
    wr_port_t  mem_wr,
    wr_port_t  wb_wr
);
    rv32i_word val;
    val = rf_data;
    if (rs != '0) begin
        if (exe_held && exe_last.reg_we && exe_last.rd == rs) begin
            val = exe_last.alu_out;
        end else if (mem_wr.we && mem_wr.rd == rs) begin
            val = mem_wr.data;
        end else if (wb_wr.we && wb_wr.rd == rs) begin
            val = wb_wr.data;
        end
    end
    return val;
endfunction

`endif

//--- tb_exe_subsystem.sv
`default_nettype none

module tb_exe_subsystem
import rv32i_pkg::*;
();

    `include "tb_exe_ref.svh"

    localparam int N_ALU    = 10 * 2 * 6 * 3;
    localparam int N_CMP    = 6 * 2 * 4;
    localparam int N_FWD    = 200;
    localparam int N_STALL  = 200;
    localparam int N_STREAM = 100;
    // two resets around the first test, two idle cycles after each of six tests
    localparam int MAX_CYCLES = 16 + 1 + 1 + 16 + 1 + N_ALU + N_CMP + N_FWD + N_STALL
                                + N_STREAM + 6 * 2 + 200;

    logic     clk;
    logic     rst;
    de_exe_t  de;
    logic     de_valid;
    logic     mem_rdy;
    wr_port_t mem_wr;
    wr_port_t wb_wr;
    exe_mem_t exe_o;
    logic     exe_valid;

    integer   seed = 32'hce32f54b;
    int       errors = 0;
    int       checks = 0;
    int       test_base = 0;
    int       cycles = 0;
    wr_port_t no_wr = '0;
    cmp_op_t  cmp_ops [6] = '{beq, bne, blt, bge, bltu, bgeu};

    // scoreboard model of the held result
    logic     exp_valid = 1'b0;
    logic     held = 1'b0;
    exe_mem_t last_exp = '0;

    exe_subsystem UUT (
        .clk         (clk),
        .rst         (rst),
        .de_i        (de),
        .de_valid_i  (de_valid),
        .mem_rdy_i   (mem_rdy),
        .mem_wr_i    (mem_wr),
        .wb_wr_i     (wb_wr),
        .exe_o       (exe_o),
        .exe_valid_o (exe_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected exe_mem_t for one accepted instruction
    function automatic exe_mem_t expect_result(de_exe_t d, wr_port_t m, wr_port_t w,
                                               logic h, exe_mem_t last);
        exe_mem_t  r;
        rv32i_word rs1v;
        rv32i_word rs2v;
        rv32i_word a;
        rv32i_word b;
        rv32i_word cb;
        rs1v = ref_operand(d.ctrl.rs1, d.rs1_data, h, last, m, w);
        rs2v = ref_operand(d.ctrl.rs2, d.rs2_data, h, last, m, w);
        a = (d.ctrl.alumux1_sel == alumux1_pc_out) ? d.pc : rs1v;
        case (d.ctrl.alumux2_sel)
            alumux2_i_imm: b = d.imm.i_imm;
            alumux2_u_imm: b = d.imm.u_imm;
            alumux2_b_imm: b = d.imm.b_imm;
            alumux2_s_imm: b = d.imm.s_imm;
            alumux2_j_imm: b = d.imm.j_imm;
            default:       b = rs2v;
        endcase
        cb = (d.ctrl.cmp_sel == cmpmux_i_imm) ? d.imm.i_imm : rs2v;
        r.alu_out = ref_alu(d.ctrl.aluop, a, b);
        r.rs2_out = rs2v;
        r.br_en   = ref_cmp(d.ctrl.cmpop, rs1v, cb);
        r.rd      = d.ctrl.rd;
        r.reg_we  = d.ctrl.reg_we;
        return r;
    endfunction

    // capture the expectation at each acceptance
    always @(posedge clk) begin
        if (rst) begin
            exp_valid = 1'b0;
            held = 1'b0;
        end else begin
            exp_valid = de_valid && mem_rdy;
            if (exp_valid) begin
                last_exp = expect_result(de, mem_wr, wb_wr, held, last_exp);
                held = 1'b1;
            end
        end
    end

    task automatic check_exe(exe_mem_t got, exe_mem_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s alu_out %h rs2_out %h br_en %b, expected %h %h %b",
                     $time, what, got.alu_out, got.rs2_out, got.br_en,
                     exp.alu_out, exp.rs2_out, exp.br_en);
        end
    endtask

    task automatic check_valid(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        check_valid(exe_valid, exp_valid, "exe_valid_o");
        if (held) begin
            check_exe(exe_o, last_exp, "exe_o");
        end
    end

    function automatic int rand_below(int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic de_exe_t rand_de(rv32i_reg mask);
        de_exe_t d;
        d.pc               = $random(seed);
        d.rs1_data         = $random(seed);
        d.rs2_data         = $random(seed);
        d.imm              = {$random(seed), $random(seed), $random(seed),
                              $random(seed), $random(seed)};
        d.ctrl.aluop       = alu_op_t'(4'(rand_below(10)));
        d.ctrl.cmpop       = cmp_ops[rand_below(6)];
        d.ctrl.alumux1_sel = alumux1_sel_t'(1'(rand_below(2)));
        d.ctrl.alumux2_sel = alumux2_sel_t'(3'(rand_below(6)));
        d.ctrl.cmp_sel     = cmpmux_sel_t'(1'(rand_below(2)));
        d.ctrl.rs1         = 5'(rand_below(32)) & mask;
        d.ctrl.rs2         = 5'(rand_below(32)) & mask;
        d.ctrl.rd          = 5'(rand_below(32)) & mask;
        d.ctrl.reg_we      = 1'(rand_below(2));
        return d;
    endfunction

    function automatic wr_port_t rand_wr(rv32i_reg mask);
        wr_port_t w;
        w.we   = 1'(rand_below(2));
        w.rd   = 5'(rand_below(32)) & mask;
        w.data = $random(seed);
        return w;
    endfunction

    // drive one cycle of inputs, just after the rising edge
    task automatic apply(de_exe_t d, logic valid, logic rdy, wr_port_t m, wr_port_t w);
        de       = d;
        de_valid = valid;
        mem_rdy  = rdy;
        mem_wr   = m;
        wb_wr    = w;
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(string name);
        apply(de, 1'b0, 1'b1, no_wr, no_wr);
        apply(de, 1'b0, 1'b1, no_wr, no_wr);
        $display("%-8s done, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic run_alu();
        de_exe_t d;
        for (int op = 0; op < 10; op++) begin
            for (int m1 = 0; m1 < 2; m1++) begin
                for (int m2 = 0; m2 < 6; m2++) begin
                    for (int it = 0; it < 3; it++) begin
                        d = rand_de(5'd31);
                        d.ctrl.aluop       = alu_op_t'(4'(op));
                        d.ctrl.alumux1_sel = alumux1_sel_t'(1'(m1));
                        d.ctrl.alumux2_sel = alumux2_sel_t'(3'(m2));
                        if (it == 1) begin
                            // shift amount 31 with upper bits set
                            d.rs2_data[4:0]   = 5'd31;
                            d.rs2_data[8]     = 1'b1;
                            d.imm.i_imm[4:0]  = 5'd31;
                            d.imm.i_imm[31]   = 1'b1;
                        end else if (it == 2) begin
                            // operands of opposite sign
                            d.rs1_data[31]  = 1'b1;
                            d.pc[31]        = 1'b1;
                            d.rs2_data[31]  = 1'b0;
                            d.imm.i_imm[31] = 1'b0;
                        end
                        apply(d, 1'b1, 1'b1, no_wr, no_wr);
                    end
                end
            end
        end
        finish_test("alu");
    endtask

    task automatic run_cmp();
        de_exe_t   d;
        rv32i_word b;
        for (int k = 0; k < 6; k++) begin
            for (int s = 0; s < 2; s++) begin
                for (int c = 0; c < 4; c++) begin
                    // x0 operands, so the register data is used as is
                    d = rand_de(5'd0);
                    d.ctrl.cmpop   = cmp_ops[k];
                    d.ctrl.cmp_sel = cmpmux_sel_t'(1'(s));
                    case (c)
                        0:       b = d.rs1_data;
                        1:       b = d.rs1_data - 32'd1;
                        2:       b = d.rs1_data + 32'd1;
                        default: b = d.rs1_data ^ 32'h8000_0000;
                    endcase
                    // unselected source differs so a wrong mux shows
                    if (s == 1) begin
                        d.imm.i_imm = b;
                        d.rs2_data  = ~b;
                    end else begin
                        d.rs2_data  = b;
                        d.imm.i_imm = ~b;
                    end
                    apply(d, 1'b1, 1'b1, no_wr, no_wr);
                end
            end
        end
        finish_test("cmp");
    endtask

    task automatic run_fwd();
        de_exe_t  d;
        wr_port_t m;
        wr_port_t w;
        rv32i_reg prev_rd;
        prev_rd = 5'd1;
        for (int i = 0; i < N_FWD; i++) begin
            d = rand_de(5'd3);
            m = rand_wr(5'd3);
            w = rand_wr(5'd3);
            d.ctrl.alumux1_sel = alumux1_rs1_out;
            d.ctrl.alumux2_sel = alumux2_rs2_out;
            if (i % 4 == 0) begin
                // exe, mem and wb all write the source register
                d.ctrl.rs1 = prev_rd;
                d.ctrl.rs2 = prev_rd;
                m.we = 1'b1;
                m.rd = prev_rd;
                w.we = 1'b1;
                w.rd = prev_rd;
            end else if (i % 4 == 1) begin
                m.we = 1'b1;
                m.rd = d.ctrl.rs1;
                w.we = 1'b1;
                w.rd = d.ctrl.rs1;
            end
            apply(d, 1'b1, 1'b1, m, w);
            prev_rd = d.ctrl.rd;
        end
        finish_test("fwd");
    endtask

    task automatic run_stall(int n, logic stalls, string name);
        de_exe_t d;
        logic    valid;
        logic    rdy;
        for (int i = 0; i < n; i++) begin
            d     = rand_de(5'd3);
            valid = stalls ? (rand_below(4) != 0) : 1'b1;
            rdy   = stalls ? 1'(rand_below(2)) : 1'b1;
            apply(d, valid, rdy, rand_wr(5'd3), rand_wr(5'd3));
        end
        finish_test(name);
    endtask

    initial begin
        de_exe_t d;
        rst      = 1'b1;
        de       = '0;
        de_valid = 1'b0;
        mem_rdy  = 1'b0;
        mem_wr   = '0;
        wb_wr    = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        check_valid(exe_valid, 1'b0, "exe_valid_o after reset");
        // load a write to x1, then reset again before reading x1
        d = rand_de(5'd0);
        d.ctrl.rs1         = 5'd1;
        d.ctrl.rs2         = 5'd1;
        d.ctrl.rd          = 5'd1;
        d.ctrl.reg_we      = 1'b1;
        d.ctrl.alumux1_sel = alumux1_rs1_out;
        d.ctrl.alumux2_sel = alumux2_rs2_out;
        apply(d, 1'b1, 1'b1, no_wr, no_wr);
        apply(d, 1'b0, 1'b1, no_wr, no_wr);
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        check_valid(exe_valid, 1'b0, "exe_valid_o after second reset");
        // held write to x1 is stale now and must not forward
        d.rs1_data = $random(seed);
        d.rs2_data = $random(seed);
        apply(d, 1'b1, 1'b1, no_wr, no_wr);
        finish_test("reset");

        run_alu();
        run_cmp();
        run_fwd();
        run_stall(N_STALL, 1'b1, "stall");
        run_stall(N_STREAM, 1'b0, "stream");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule : tb_exe_subsystem

`default_nettype wire

//--- exe_subsystem.sv
`default_nettype none

module exe_subsystem
import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  de_exe_t  de_i,
    input  logic     de_valid_i,
    input  logic     mem_rdy_i,
    input  wr_port_t mem_wr_i,
    input  wr_port_t wb_wr_i,
    output exe_mem_t exe_o,
    output logic     exe_valid_o
);

    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;
    wr_port_t exe_wr;

    fwd_unit fwd_unit_i (
        .ctrl_i    (de_i.ctrl),
        .exe_wr_i  (exe_wr),
        .mem_wr_i  (mem_wr_i),
        .wb_wr_i   (wb_wr_i),
        .rs1_sel_o (rs1_sel),
        .rs2_sel_o (rs2_sel)
    );

    // held result comes back as the exe write port
    exe_stage exe_stage_i (
        .clk         (clk),
        .rst         (rst),
        .de_i        (de_i),
        .de_valid_i  (de_valid_i),
        .mem_rdy_i   (mem_rdy_i),
        .rs1_sel_i   (rs1_sel),
        .rs2_sel_i   (rs2_sel),
        .mem_fwd_i   (mem_wr_i.data),
        .wb_fwd_i    (wb_wr_i.data),
        .exe_o       (exe_o),
        .exe_wr_o    (exe_wr),
        .exe_valid_o (exe_valid_o)
    );

endmodule : exe_subsystem

`default_nettype wire

//--- exe_stage.sv
`default_nettype none

module exe_stage
import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  de_exe_t   de_i,
    input  logic      de_valid_i,
    input  logic      mem_rdy_i,
    input  fwd_sel_t  rs1_sel_i,
    input  fwd_sel_t  rs2_sel_i,
    input  rv32i_word mem_fwd_i,
    input  rv32i_word wb_fwd_i,
    output exe_mem_t  exe_o,
    output wr_port_t  exe_wr_o,
    output logic      exe_valid_o
);

    exe_ctrl_t ctrl;
    imm_t      imm;
    rv32i_word rs1_val;
    rv32i_word rs2_val;
    rv32i_word alu_a;
    rv32i_word alu_b;
    rv32i_word cmp_b;
    rv32i_word alu_f;
    logic      br_en;
    logic      accept;
    logic      held_valid;
    exe_mem_t  exe_q;

    assign ctrl   = de_i.ctrl;
    assign imm    = de_i.imm;
    assign accept = de_valid_i & mem_rdy_i;

    // operand source after forwarding
    function automatic rv32i_word fwd_pick(fwd_sel_t sel, rv32i_word rf_data);
        rv32i_word val;
        case (sel)
            from_exe: val = exe_q.alu_out;
            from_mem: val = mem_fwd_i;
            from_wb:  val = wb_fwd_i;
            default:  val = rf_data;
        endcase
        return val;
    endfunction

    always_comb begin : operand_fwd
        rs1_val = fwd_pick(rs1_sel_i, de_i.rs1_data);
        rs2_val = fwd_pick(rs2_sel_i, de_i.rs2_data);
    end

    always_comb begin : exe_mux
        case (ctrl.alumux1_sel)
            alumux1_pc_out: alu_a = de_i.pc;
            default:        alu_a = rs1_val;
        endcase

        case (ctrl.alumux2_sel)
            alumux2_i_imm:   alu_b = imm.i_imm;
            alumux2_u_imm:   alu_b = imm.u_imm;
            alumux2_b_imm:   alu_b = imm.b_imm;
            alumux2_s_imm:   alu_b = imm.s_imm;
            alumux2_j_imm:   alu_b = imm.j_imm;
            alumux2_rs2_out: alu_b = rs2_val;
            default:         alu_b = '0;
        endcase

        case (ctrl.cmp_sel)
            cmpmux_i_imm: cmp_b = imm.i_imm;
            default:      cmp_b = rs2_val;
        endcase
    end

    alu alu_i (
        .aluop_i (ctrl.aluop),
        .a_i     (alu_a),
        .b_i     (alu_b),
        .f_o     (alu_f)
    );

    cmp cmp_i (
        .cmpop_i (ctrl.cmpop),
        .a_i     (rs1_val),
        .b_i     (cmp_b),
        .br_en_o (br_en)
    );

    // result for the memory stage, loaded on acceptance only
    always_ff @(posedge clk) begin
        if (accept) begin
            exe_q <= '{alu_out: alu_f, rs2_out: rs2_val, br_en: br_en,
                       rd: ctrl.rd, reg_we: ctrl.reg_we};
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            exe_valid_o <= 1'b0;
            held_valid  <= 1'b0;
        end else begin
            exe_valid_o <= accept;
            // register holds a real instruction from the first acceptance on
            if (accept) begin
                held_valid <= 1'b1;
            end
        end
    end

    assign exe_o    = exe_q;
    assign exe_wr_o = '{we: held_valid & exe_q.reg_we, rd: exe_q.rd, data: exe_q.alu_out};

    valid_after_accept: assert property (
        @(posedge clk) disable iff (rst)
        exe_valid_o |-> $past(de_valid_i && mem_rdy_i)
    ) else $error("exe_valid_o without acceptance");

    hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        !mem_rdy_i |=> $stable(exe_o)
    ) else $error("exe_o changed while memory stage not ready");

endmodule : exe_stage

`default_nettype wire

//--- fwd_unit.sv
`default_nettype none

module fwd_unit
import rv32i_pkg::*;
(
    input  exe_ctrl_t ctrl_i,
    input  wr_port_t  exe_wr_i,
    input  wr_port_t  mem_wr_i,
    input  wr_port_t  wb_wr_i,
    output fwd_sel_t  rs1_sel_o,
    output fwd_sel_t  rs2_sel_o
);

    // nearest matching writer wins, x0 always reads the register file
    function automatic fwd_sel_t pick_src(
        rv32i_reg rs,
        wr_port_t exe_wr,
        wr_port_t mem_wr,
        wr_port_t wb_wr
    );
        fwd_sel_t sel;
        sel = reg_file;
        if (rs != '0) begin
            if (exe_wr.we && exe_wr.rd == rs) begin
                sel = from_exe;
            end else if (mem_wr.we && mem_wr.rd == rs) begin
                sel = from_mem;
            end else if (wb_wr.we && wb_wr.rd == rs) begin
                sel = from_wb;
            end
        end
        return sel;
    endfunction

    assign rs1_sel_o = pick_src(ctrl_i.rs1, exe_wr_i, mem_wr_i, wb_wr_i);
    assign rs2_sel_o = pick_src(ctrl_i.rs2, exe_wr_i, mem_wr_i, wb_wr_i);

    // no clock here, so checked once the inputs have settled
    x0_no_fwd: assert final (
        (ctrl_i.rs1 != '0 || rs1_sel_o == reg_file) &&
        (ctrl_i.rs2 != '0 || rs2_sel_o == reg_file)
    ) else $error("forwarding selected for register x0");

endmodule : fwd_unit

`default_nettype wire

//--- cmp.sv
`default_nettype none

module cmp
import rv32i_pkg::*;
(
    input  cmp_op_t   cmpop_i,
    input  rv32i_word a_i,
    input  rv32i_word b_i,
    output logic      br_en_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (cmpop_i)
            beq:     br_en_o = eq;
            bne:     br_en_o = ~eq;
            blt:     br_en_o = lt_s;
            bge:     br_en_o = ~lt_s;
            bltu:    br_en_o = lt_u;
            bgeu:    br_en_o = ~lt_u;
            default: br_en_o = 1'b0;
        endcase
    end

endmodule : cmp

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu
import rv32i_pkg::*;
(
    input  alu_op_t   aluop_i,
    input  rv32i_word a_i,
    input  rv32i_word b_i,
    output rv32i_word f_o
);

    logic [4:0] shamt;

    // only the low five bits shift
    assign shamt = b_i[4:0];

    always_comb begin
        case (aluop_i)
            alu_add:  f_o = a_i + b_i;
            alu_sub:  f_o = a_i - b_i;
            alu_sll:  f_o = a_i << shamt;
            alu_slt:  f_o = {31'd0, $signed(a_i) < $signed(b_i)};
            alu_sltu: f_o = {31'd0, a_i < b_i};
            alu_xor:  f_o = a_i ^ b_i;
            alu_srl:  f_o = a_i >> shamt;
            alu_sra:  f_o = rv32i_word'($signed(a_i) >>> shamt);
            alu_or:   f_o = a_i | b_i;
            alu_and:  f_o = a_i & b_i;
            // unused encodings
            default:  f_o = '0;
        endcase
    end

endmodule : alu

`default_nettype wire

//--- rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // alu operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // branch conditions, encoded as funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    // operand source chosen by forwarding
    typedef enum logic [1:0] {
        reg_file = 2'b00,
        from_exe = 2'b01,
        from_mem = 2'b10,
        from_wb  = 2'b11
    } fwd_sel_t;

    // mux selects carry a prefix since several share a name
    typedef enum logic {
        alumux1_rs1_out = 1'b0,
        alumux1_pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm   = 3'd0,
        alumux2_u_imm   = 3'd1,
        alumux2_b_imm   = 3'd2,
        alumux2_s_imm   = 3'd3,
        alumux2_j_imm   = 3'd4,
        alumux2_rs2_out = 3'd5
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux_rs2_out = 1'b0,
        cmpmux_i_imm   = 1'b1
    } cmpmux_sel_t;

    typedef struct packed {
        rv32i_word i_imm;
        rv32i_word s_imm;
        rv32i_word b_imm;
        rv32i_word u_imm;
        rv32i_word j_imm;
    } imm_t;

    typedef struct packed {
        alu_op_t      aluop;
        cmp_op_t      cmpop;
        alumux1_sel_t alumux1_sel;
        alumux2_sel_t alumux2_sel;
        cmpmux_sel_t  cmp_sel;
        rv32i_reg     rs1;
        rv32i_reg     rs2;
        rv32i_reg     rd;
        logic         reg_we;
    } exe_ctrl_t;

    // decode to execute payload
    typedef struct packed {
        exe_ctrl_t ctrl;
        rv32i_word pc;
        rv32i_word rs1_data;
        rv32i_word rs2_data;
        imm_t      imm;
    } de_exe_t;

    // pending register write of a younger stage
    typedef struct packed {
        logic      we;
        rv32i_reg  rd;
        rv32i_word data;
    } wr_port_t;

    typedef struct packed {
        rv32i_word alu_out;
        rv32i_word rs2_out;
        logic      br_en;
        rv32i_reg  rd;
        logic      reg_we;
    } exe_mem_t;

endpackage : rv32i_pkg

`default_nettype wire
